// ==== hw/dino_pkg.sv ====
package dino_pkg;

	// Screen coordinates and game counts
	typedef logic [8:0] x_t;
	typedef logic [7:0] y_t;
	typedef logic signed [9:0] vel_t; // Negative is upward
	typedef logic [15:0] score_t;

	localparam x_t XSCREEN = 9'd320;
	localparam int TICK_DIV = 16; // Clock cycles per game tick

	// Runner placement and hit box
	localparam x_t DINO_X = 9'd52;
	localparam y_t GROUND_Y = 8'd109;
	localparam x_t DINO_X_OFS = 9'd6;
	localparam x_t DINO_W = 9'd20;
	localparam y_t STAND_TOP_OFS = 8'd2;
	localparam y_t STAND_H = 8'd28;
	localparam y_t DUCK_TOP_OFS = 8'd16; // Head drops when ducking
	localparam y_t DUCK_H = 8'd16;

	// Jump physics, in pixels per tick
	localparam vel_t JUMP_FORCE = 10'sd12;
	localparam vel_t GRAVITY = 10'sd1;
	localparam int DUCK_TICKS = 24;

	// Obstacle geometry and motion
	localparam x_t OBS_W = 9'd16;
	localparam y_t OBS_H = 8'd16;
	localparam x_t OBS_STEP = 9'd3;
	localparam x_t OBS_X_INIT = 9'd304;
	localparam y_t GROUND_LANE_Y = 8'd118;
	localparam y_t HIGH_LANE_Y = 8'd100; // Clears a ducking runner

	// Respawn offset range and LFSR start
	localparam int RESPAWN_SPAN = 100;
	localparam logic [15:0] LFSR_SEED = 16'hACE1;

endpackage

// ==== hw/hitbox_if.sv ====
`timescale 1ns/1ps

// Edges of one object's collision box, in screen pixels
interface hitbox_if import dino_pkg::*; ();

	x_t left;
	x_t right;
	y_t top;
	y_t bottom;

	modport source (
		output left, right, top, bottom
	);

	modport sink (
		input left, right, top, bottom
	);

endinterface

// ==== hw/dino_runner.sv ====
`timescale 1ns/1ps

module dino_runner import dino_pkg::*; (
	input  logic Clock,
	input  logic rst_n,
	input  logic i_tick,
	input  logic i_jump,
	input  logic i_duck,
	input  logic i_restart,
	input  logic i_game_over,
	output y_t   o_y,
	output logic o_ducking,
	hitbox_if.source box
);

	typedef enum logic {S_GROUND, S_AIR} run_state_t;

	run_state_t state;
	vel_t vel;
	y_t y;
	logic [4:0] duck_cnt;
	logic jump_pend; // Key seen since the last tick
	logic ducking;
	logic start_jump;
	logic start_duck;
	logic signed [10:0] next_y;

	assign ducking = (duck_cnt != 5'd0);
	assign next_y = $signed({3'b000, y}) + vel;

	// Jump wins over a duck requested on the same cycle
	assign start_jump = i_tick && (state == S_GROUND) && !ducking && (jump_pend || i_jump);
	assign start_duck = i_duck && (state == S_GROUND) && !ducking && !start_jump;

	always_ff @(posedge Clock) begin
		if (!rst_n || i_restart) begin
			state <= S_GROUND;
			vel <= '0;
			y <= GROUND_Y;
			duck_cnt <= '0;
			jump_pend <= 1'b0;
		end else if (!i_game_over) begin
			if (i_tick)
				jump_pend <= 1'b0;
			else if (i_jump && state == S_GROUND && !ducking)
				jump_pend <= 1'b1;

			if (start_duck)
				duck_cnt <= 5'(DUCK_TICKS);
			else if (i_tick && ducking)
				duck_cnt <= duck_cnt - 5'd1;

			if (start_jump) begin
				state <= S_AIR;
				vel <= -JUMP_FORCE; // y moves from the following tick on
			end else if (i_tick && state == S_AIR) begin
				if (next_y >= $signed({3'b000, GROUND_Y})) begin
					y <= GROUND_Y; // Landed
					vel <= '0;
					state <= S_GROUND;
				end else begin
					y <= y_t'(next_y);
					vel <= vel + GRAVITY;
				end
			end
		end
	end

	assign o_y = y;
	assign o_ducking = ducking;

	// Fixed horizontal box, vertical box follows the posture
	assign box.left = DINO_X + DINO_X_OFS;
	assign box.right = DINO_X + DINO_X_OFS + DINO_W;
	assign box.top = y + (ducking ? DUCK_TOP_OFS : STAND_TOP_OFS);
	assign box.bottom = y + (ducking ? (DUCK_TOP_OFS + DUCK_H) : (STAND_TOP_OFS + STAND_H));

endmodule

// ==== hw/obstacle_lane.sv ====
`timescale 1ns/1ps

module obstacle_lane import dino_pkg::*; (
	input  logic Clock,
	input  logic rst_n,
	input  logic i_tick,
	input  logic i_respawn,
	input  logic i_restart,
	input  logic i_game_over,
	output x_t   o_x,
	output y_t   o_y,
	hitbox_if.source box
);

	logic [15:0] lfsr;
	logic feedback;
	x_t resp_ofs;
	x_t x;
	logic lane_high; // 0 ground lane, 1 high lane
	logic reload;
	y_t y;

	assign feedback = lfsr[15] ^ lfsr[14] ^ lfsr[12] ^ lfsr[3];

	// Free-running random source
	always_ff @(posedge Clock) begin
		if (!rst_n || i_restart)
			lfsr <= LFSR_SEED;
		else
			lfsr <= {lfsr[14:0], feedback};
	end

	// Offset 0 to 99 past the right screen edge
	always_ff @(posedge Clock) begin
		resp_ofs <= x_t'(lfsr[8:0] % RESPAWN_SPAN);
	end

	// Wrap at the left edge or respawn after a pass
	assign reload = i_respawn || (i_tick && x <= OBS_STEP);

	always_ff @(posedge Clock) begin
		if (!rst_n || i_restart) begin
			x <= OBS_X_INIT;
			lane_high <= 1'b0;
		end else if (!i_game_over) begin
			if (reload) begin
				x <= XSCREEN - OBS_W + resp_ofs;
				lane_high <= lfsr[15];
			end else if (i_tick) begin
				x <= x - OBS_STEP;
			end
		end
	end

	assign y = lane_high ? HIGH_LANE_Y : GROUND_LANE_Y;

	assign o_x = x;
	assign o_y = y;

	assign box.left = x;
	assign box.right = x + OBS_W;
	assign box.top = y;
	assign box.bottom = y + OBS_H;

endmodule

// ==== hw/game_referee.sv ====
`timescale 1ns/1ps

module game_referee import dino_pkg::*; (
	input  logic   Clock,
	input  logic   rst_n,
	input  logic   i_restart,
	hitbox_if.sink dino,
	hitbox_if.sink obs,
	output logic   o_game_over,
	output logic   o_respawn,
	output score_t o_score,
	output score_t o_high_score
);

	logic overlap;
	logic prev_overlap;
	x_t prev_left; // Obstacle left edge one cycle ago
	logic game_over;
	logic game_over_d;
	logic pass;
	score_t score;
	score_t high_score;

	// Boxes touch on both axes
	assign overlap = (dino.right >= obs.left) && (dino.left <= obs.right) &&
		(dino.bottom >= obs.top) && (dino.top <= obs.bottom);

	// Obstacle crossed the runner's position cleanly
	assign pass = (prev_left > DINO_X) && (obs.left <= DINO_X) &&
		!overlap && !prev_overlap && !game_over;

	always_ff @(posedge Clock) begin
		if (!rst_n || i_restart) begin
			prev_left <= '0;
			prev_overlap <= 1'b0;
			game_over <= 1'b0;
			game_over_d <= 1'b0;
			score <= '0;
			o_respawn <= 1'b0;
		end else begin
			prev_left <= obs.left;
			prev_overlap <= overlap;
			game_over_d <= game_over;
			o_respawn <= pass;
			if (overlap)
				game_over <= 1'b1; // Sticky until restart
			if (pass)
				score <= score + 16'd1;
		end
	end

	// Best round survives a restart
	always_ff @(posedge Clock) begin
		if (!rst_n)
			high_score <= '0;
		else if (game_over && !game_over_d && score > high_score)
			high_score <= score;
	end

	assign o_game_over = game_over;
	assign o_score = score;
	assign o_high_score = high_score;

endmodule

// ==== hw/dino_game_top.sv ====
`timescale 1ns/1ps

module dino_game_top import dino_pkg::*; (
	input  logic   Clock,
	input  logic   rst_n,
	input  logic   i_jump_key,
	input  logic   i_duck_key,
	input  logic   i_restart,
	output y_t     o_dino_y,
	output logic   o_dino_ducking,
	output x_t     o_obstacle_x,
	output y_t     o_obstacle_y,
	output logic   o_game_over,
	output score_t o_score,
	output score_t o_high_score
);

	logic [2:0] key_meta;
	logic [2:0] key_sync; // {restart, duck, jump}
	logic [$clog2(TICK_DIV)-1:0] tick_cnt;
	logic game_tick;
	logic game_over;
	logic respawn;

	hitbox_if dino_box ();
	hitbox_if obs_box ();

	// Two-flop synchronizers for the key levels
	always_ff @(posedge Clock) begin
		if (!rst_n) begin
			key_meta <= '0;
			key_sync <= '0;
		end else begin
			key_meta <= {i_restart, i_duck_key, i_jump_key};
			key_sync <= key_meta;
		end
	end

	// Game tick divider
	always_ff @(posedge Clock) begin
		if (!rst_n)
			tick_cnt <= '0;
		else if (tick_cnt == TICK_DIV - 1)
			tick_cnt <= '0;
		else
			tick_cnt <= tick_cnt + 1'b1;
	end

	assign game_tick = (tick_cnt == TICK_DIV - 1);

	dino_runner u_runner (
		.Clock       (Clock),
		.rst_n       (rst_n),
		.i_tick      (game_tick),
		.i_jump      (key_sync[0]),
		.i_duck      (key_sync[1]),
		.i_restart   (key_sync[2]),
		.i_game_over (game_over),
		.o_y         (o_dino_y),
		.o_ducking   (o_dino_ducking),
		.box         (dino_box.source)
	);

	obstacle_lane u_lane (
		.Clock       (Clock),
		.rst_n       (rst_n),
		.i_tick      (game_tick),
		.i_respawn   (respawn),
		.i_restart   (key_sync[2]),
		.i_game_over (game_over),
		.o_x         (o_obstacle_x),
		.o_y         (o_obstacle_y),
		.box         (obs_box.source)
	);

	game_referee u_referee (
		.Clock        (Clock),
		.rst_n        (rst_n),
		.i_restart    (key_sync[2]),
		.dino         (dino_box.sink),
		.obs          (obs_box.sink),
		.o_game_over  (game_over),
		.o_respawn    (respawn),
		.o_score      (o_score),
		.o_high_score (o_high_score)
	);

	assign o_game_over = game_over;

endmodule

// ==== dv/game_chk.sv ====
`timescale 1ns/1ps

// Protocol properties of the referee outputs
module game_chk import dino_pkg::*; (
	input logic   Clock,
	input logic   rst_n,
	input logic   i_restart,
	input logic   i_game_over,
	input logic   i_respawn,
	input score_t i_score,
	input score_t i_high_score
);

	int fail_count = 0; // Failed assertions so far

	a_respawn_pulse: assert property (@(posedge Clock) disable iff (!rst_n)
		i_respawn |=> !i_respawn)
		else begin
			fail_count++;
			$error("respawn stayed high for more than one cycle");
		end

	// Only restart may clear the latch
	a_game_over_sticky: assert property (@(posedge Clock) disable iff (!rst_n)
		i_game_over && !i_restart |=> i_game_over)
		else begin
			fail_count++;
			$error("game over fell without restart or reset");
		end

	a_score_frozen: assert property (@(posedge Clock) disable iff (!rst_n)
		i_game_over && !i_restart |=> $stable(i_score))
		else begin
			fail_count++;
			$error("score changed while game over was high");
		end

	a_high_monotonic: assert property (@(posedge Clock) disable iff (!rst_n)
		1'b1 |=> i_high_score >= $past(i_high_score))
		else begin
			fail_count++;
			$error("high score decreased");
		end

endmodule

// ==== dv/game_scoreboard.sv ====
`timescale 1ns/1ps

module game_scoreboard import dino_pkg::*; (
	input logic   Clock,
	input logic   rst_n,
	input y_t     i_dino_y,
	input logic   i_ducking,
	input x_t     i_obs_x,
	input y_t     i_obs_y,
	input logic   i_game_over,
	input score_t i_score
);

	int proc_errors = 0; // Found by the compare process
	int task_errors = 0; // Found by checks the testbench asks for
	int tests = 0;
	int failed = 0;
	int test_start = 0;
	logic valid = 1'b0;
	y_t p_y;
	logic p_duck;
	x_t p_x;
	y_t p_oy;
	logic p_go;
	score_t p_score;
	logic pend = 1'b0; // A clean pass was seen on the last sample
	score_t pend_score;

	// Hit-box overlap from the geometry constants
	function automatic logic overlap(y_t dy, logic duck, x_t ox, y_t oy);
		int dl;
		int dr;
		int dt;
		int db;
		dl = DINO_X + DINO_X_OFS;
		dr = dl + DINO_W;
		dt = dy + (duck ? DUCK_TOP_OFS : STAND_TOP_OFS);
		db = duck ? dt + DUCK_H : dt + STAND_H;
		return (dr >= ox) && (dl <= ox + OBS_W) && (db >= oy) && (dt <= oy + OBS_H);
	endfunction

	// Highest point as the sum of the shrinking upward steps
	function automatic int jump_peak();
		int v;
		int y;
		v = JUMP_FORCE;
		y = GROUND_Y;
		while (v > 0) begin
			y = y - v;
			v = v - GRAVITY;
		end
		return y;
	endfunction

	function automatic logic respawn_ok(x_t x);
		return (x >= XSCREEN - OBS_W) && (x <= XSCREEN - OBS_W + RESPAWN_SPAN - 1);
	endfunction

	function automatic int max_score(int a, int b);
		return (a > b) ? a : b;
	endfunction

	function automatic void show_fail(string msg);
		$display("CHECK FAILED at %0t: %0s", $time, msg);
	endfunction

	function automatic int error_count();
		return proc_errors + task_errors;
	endfunction

	task automatic check(input logic ok, input string msg);
		if (!ok) begin
			show_fail(msg);
			task_errors++;
		end
	endtask

	task automatic begin_test();
		test_start = error_count();
	endtask

	task automatic end_test(input string name);
		int n;
		n = error_count() - test_start;
		tests++;
		if (n == 0) begin
			$display("Test %0s: passed", name);
		end else begin
			failed++;
			$display("Test %0s: FAILED with %0d check errors", name, n);
		end
	endtask

	task automatic report(input int assert_fails);
		$display("Summary: %0d tests, %0d failed, %0d check errors, %0d assertion failures",
			tests, failed, error_count(), assert_fails);
	endtask

	// Samples hold the state after the previous edge
	always @(posedge Clock) begin
		if (!rst_n) begin
			valid = 1'b0;
			pend = 1'b0;
		end else begin
			if (valid) begin
				if (!p_go && (i_game_over != overlap(p_y, p_duck, p_x, p_oy))) begin
					show_fail($sformatf("game over %0b does not follow the overlap", i_game_over));
					proc_errors++;
				end
				if (p_go && i_game_over && (i_obs_x != p_x || i_dino_y != p_y)) begin
					show_fail("objects moved during game over");
					proc_errors++;
				end
				if (pend && i_score != pend_score + 16'd1) begin
					show_fail($sformatf("score %0d after a pass, expected %0d", i_score,
						pend_score + 16'd1));
					proc_errors++;
				end else if (!pend && i_score != p_score && i_score != 0) begin
					show_fail($sformatf("score changed to %0d without a pass", i_score));
					proc_errors++;
				end
				if (i_obs_x > p_x && !respawn_ok(i_obs_x)) begin
					show_fail($sformatf("respawn x %0d out of range", i_obs_x));
					proc_errors++;
				end
			end
			if (i_obs_y != GROUND_LANE_Y && i_obs_y != HIGH_LANE_Y) begin
				show_fail($sformatf("obstacle lane y %0d is not a lane", i_obs_y));
				proc_errors++;
			end
			if (i_dino_y < jump_peak() || i_dino_y > GROUND_Y) begin
				show_fail($sformatf("runner y %0d out of range", i_dino_y));
				proc_errors++;
			end
			pend = valid && p_x > DINO_X && i_obs_x <= DINO_X && !i_game_over &&
				!overlap(p_y, p_duck, p_x, p_oy) && !overlap(i_dino_y, i_ducking, i_obs_x, i_obs_y);
			pend_score = i_score;
			p_y = i_dino_y;
			p_duck = i_ducking;
			p_x = i_obs_x;
			p_oy = i_obs_y;
			p_go = i_game_over;
			p_score = i_score;
			valid = 1'b1;
		end
	end

endmodule

// ==== dv/tb_dino_game.sv ====
`timescale 1ns/1ps

module tb_dino_game import dino_pkg::*; ();

	// React distance that lets a jump or a duck clear the obstacle
	localparam x_t REACT_X = DINO_X + 9'd45;
	localparam int OBS_CYCLES = ((XSCREEN - OBS_W + RESPAWN_SPAN) / OBS_STEP + 1) * TICK_DIV;
	localparam int LIMIT = 2 * (20 + (OBS_CYCLES + 200) + 40 * TICK_DIV +
		4 * OBS_CYCLES + 10 * OBS_CYCLES + 12 * OBS_CYCLES);

	logic Clock;
	logic rst_n;
	logic jump_key;
	logic duck_key;
	logic restart;
	y_t dino_y;
	logic dino_ducking;
	x_t obs_x;
	y_t obs_y;
	logic game_over;
	score_t score;
	score_t high_score;

	int cycles = 0;
	int seed = 74818;
	int passes;
	x_t last_x;
	logic armed;
	int duck_cycles = 0;
	int duck_len = 0;

	dino_game_top u_dut (
		.Clock          (Clock),
		.rst_n          (rst_n),
		.i_jump_key     (jump_key),
		.i_duck_key     (duck_key),
		.i_restart      (restart),
		.o_dino_y       (dino_y),
		.o_dino_ducking (dino_ducking),
		.o_obstacle_x   (obs_x),
		.o_obstacle_y   (obs_y),
		.o_game_over    (game_over),
		.o_score        (score),
		.o_high_score   (high_score)
	);

	game_scoreboard u_sb (
		.Clock        (Clock),
		.rst_n        (rst_n),
		.i_dino_y     (dino_y),
		.i_ducking    (dino_ducking),
		.i_obs_x      (obs_x),
		.i_obs_y      (obs_y),
		.i_game_over  (game_over),
		.i_score      (score)
	);

	bind game_referee game_chk u_chk (
		.Clock        (Clock),
		.rst_n        (rst_n),
		.i_restart    (i_restart),
		.i_game_over  (o_game_over),
		.i_respawn    (o_respawn),
		.i_score      (o_score),
		.i_high_score (o_high_score)
	);

	always #10 Clock = ~Clock;

	always @(posedge Clock) begin
		cycles <= cycles + 1;
		if (cycles >= LIMIT) begin
			$display("Run timed out after %0d cycles without finishing the tests", cycles);
			$display("Errors found");
			$finish;
		end
	end

	// Length of the last duck in cycles
	always @(posedge Clock) begin
		if (dino_ducking)
			duck_cycles <= duck_cycles + 1;
		else if (duck_cycles != 0) begin
			duck_len <= duck_cycles;
			duck_cycles <= 0;
		end
	end

	// One cycle of play; act selects whether the player reacts
	task automatic play_cycle(input bit act);
		@(posedge Clock);
		jump_key <= 1'b0;
		duck_key <= 1'b0;
		if (obs_x > last_x && !game_over)
			passes++; // Respawn after a clean pass
		last_x = obs_x;
		if (obs_x > REACT_X)
			armed = 1'b1;
		else if (act && armed && obs_x > DINO_X) begin
			armed = 1'b0;
			if (obs_y == HIGH_LANE_Y)
				duck_key <= 1'b1;
			else
				jump_key <= 1'b1;
		end
	endtask

	task automatic do_restart();
		@(posedge Clock);
		restart <= 1'b1;
		repeat (4) @(posedge Clock);
		restart <= 1'b0;
		repeat (3) @(posedge Clock);
		passes = 0;
		last_x = OBS_X_INIT;
		armed = 1'b0;
	endtask

	task automatic wait_game_over();
		while (!game_over)
			play_cycle(1'b0);
		repeat (2) @(posedge Clock); // High score follows one cycle later
	endtask

	initial begin
		int min_y;
		int rounds_best;
		int n2;
		int high_pass;
		int assert_fails;
		logic air_duck;
		x_t fx;
		y_t fy;
		Clock = 1'b0;
		rst_n = 1'b0;
		jump_key = 1'b0;
		duck_key = 1'b0;
		restart = 1'b0;
		passes = 0;
		last_x = OBS_X_INIT;
		armed = 1'b0;
		rounds_best = 0;
		repeat (3) @(posedge Clock);
		rst_n <= 1'b1;
		@(posedge Clock);

		u_sb.begin_test();
		u_sb.check(score == 0 && high_score == 0, "scores not zero after reset");
		u_sb.check(!game_over, "game over set after reset");
		u_sb.check(dino_y == GROUND_Y, "runner not on the ground after reset");
		u_sb.check(obs_x == OBS_X_INIT, "obstacle not at its start after reset");
		u_sb.end_test("reset");

		// Idle runner meets the first ground obstacle
		u_sb.begin_test();
		while (!game_over)
			@(posedge Clock);
		fx = obs_x;
		fy = dino_y;
		u_sb.check(u_sb.overlap(dino_y, dino_ducking, obs_x, obs_y), "game over without overlap");
		repeat (3 * TICK_DIV) @(posedge Clock);
		u_sb.check(score == 0, "score moved in an idle round");
		u_sb.check(obs_x == fx && dino_y == fy, "positions changed after game over");
		u_sb.end_test("idle_collision");

		u_sb.begin_test();
		do_restart();
		jump_key <= 1'b1;
		@(posedge Clock);
		jump_key <= 1'b0;
		while (dino_y == GROUND_Y)
			@(posedge Clock);
		min_y = dino_y;
		air_duck = 1'b0;
		while (dino_y != GROUND_Y) begin
			@(posedge Clock);
			jump_key <= 1'b0;
			duck_key <= 1'b0;
			if (dino_y < min_y)
				min_y = dino_y;
			if (dino_y < GROUND_Y - 40 && !air_duck) begin
				air_duck = 1'b1;
				jump_key <= 1'b1;
				duck_key <= 1'b1;
			end
			u_sb.check(!dino_ducking, "duck started in the air");
		end
		u_sb.check(min_y == u_sb.jump_peak(), $sformatf("jump peak %0d, expected %0d", min_y,
			u_sb.jump_peak()));
		repeat (3 * TICK_DIV) @(posedge Clock);
		u_sb.check(dino_y == GROUND_Y && !dino_ducking, "second jump started after landing");
		u_sb.end_test("jump");

		u_sb.begin_test();
		last_x = obs_x;
		while (passes < 4 && !game_over)
			play_cycle(1'b1);
		u_sb.check(!game_over, "game over while playing by policy");
		u_sb.check(score == passes, $sformatf("score %0d after %0d passes", score, passes));
		u_sb.end_test("play");

		// Keep playing until a high lane obstacle has been ducked
		u_sb.begin_test();
		high_pass = -1;
		while ((high_pass < 0 || passes <= high_pass) && !game_over) begin
			play_cycle(1'b1);
			if (obs_y == HIGH_LANE_Y && high_pass < 0)
				high_pass = passes;
		end
		while (dino_ducking)
			play_cycle(1'b1);
		play_cycle(1'b1);
		u_sb.check(!game_over, "game over while ducking a high obstacle");
		u_sb.check(duck_len > (DUCK_TICKS - 1) * TICK_DIV && duck_len <= DUCK_TICKS * TICK_DIV,
			$sformatf("duck lasted %0d cycles", duck_len));
		u_sb.end_test("duck");

		u_sb.begin_test();
		wait_game_over();
		rounds_best = u_sb.max_score(rounds_best, passes);
		u_sb.check(high_score == rounds_best, $sformatf("high score %0d, expected %0d",
			high_score, rounds_best));
		do_restart();
		n2 = 1 + ($unsigned($random(seed)) % 2);
		while (passes < n2 && !game_over)
			play_cycle(1'b1);
		wait_game_over();
		rounds_best = u_sb.max_score(rounds_best, passes);
		u_sb.check(high_score == rounds_best, $sformatf("high score %0d after round two",
			high_score));
		do_restart();
		u_sb.check(score == 0 && !game_over, "restart did not clear the round");
		u_sb.check(high_score == rounds_best, "high score lost on restart");
		u_sb.end_test("high_score");

		assert_fails = u_dut.u_referee.u_chk.fail_count;
		u_sb.report(assert_fails);
		if (u_sb.error_count() == 0 && assert_fails == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

// ==== flist.f ====
hw/dino_pkg.sv
hw/hitbox_if.sv
hw/dino_runner.sv
hw/obstacle_lane.sv
hw/game_referee.sv
hw/dino_game_top.sv
dv/game_chk.sv
dv/game_scoreboard.sv
dv/tb_dino_game.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    = --binary --timing --assert
TOP       = tb_dino_game
FLIST     = flist.f
BUILD     = obj_dir
LOG       = sim.log
PASS_MSG  = No errors

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) && echo "Simulation passed" || \
		(echo "Simulation failed"; exit 1)

clean:
	rm -rf $(BUILD) $(LOG)
